// ==== src/fds_regs_pkg.sv ====
// CPU bus types, drive register addresses, control and status definitions
package fds_regs_pkg;

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [21:0] prg_addr_t; // Cartridge PRG space
	typedef logic [21:0] chr_addr_t; // Cartridge CHR space

	// One CPU access, valid for a single ce
	typedef struct packed {
		cpu_addr_t addr;
		byte_t     data;
		logic      read;
		logic      write;
	} cpu_bus_t;

	// Decoded $4025
	typedef struct packed {
		logic motor_on;
		logic head_rewind;
		logic vertical;      // Inverted bit 3
		logic byte_transfer;
		logic disk_irq_en;
	} disk_ctrl_t;

	localparam cpu_addr_t REG_TIMER_LO     = 16'h4020;
	localparam cpu_addr_t REG_TIMER_HI     = 16'h4021;
	localparam cpu_addr_t REG_TIMER_CTRL   = 16'h4022;
	localparam cpu_addr_t REG_IO_EN        = 16'h4023;
	localparam cpu_addr_t REG_DISK_CTRL    = 16'h4025;
	localparam cpu_addr_t REG_IRQ_STATUS   = 16'h4030;
	localparam cpu_addr_t REG_DISK_DATA    = 16'h4031;
	localparam cpu_addr_t REG_DRIVE_STATUS = 16'h4032;
	localparam cpu_addr_t REG_EXT_STATUS   = 16'h4033;

	// Battery good, nothing on the expansion port
	localparam byte_t EXT_STATUS_VAL = 8'h80;

endpackage

// ==== src/fds_disk_pkg.sv ====
// Disk image geometry, block types, side layout and end-of-side position
package fds_disk_pkg;

	typedef logic [15:0] disk_pos_t;  // Byte position within one side
	typedef logic [1:0]  disk_side_t;

	// Block type as stored in the first byte of every block
	typedef enum logic [2:0] {
		BLK_NONE        = 3'd0,
		BLK_DISK_INFO   = 3'd1,
		BLK_FILE_COUNT  = 3'd2,
		BLK_FILE_HEADER = 3'd3,
		BLK_FILE_DATA   = 3'd4
	} block_type_t;

	// Index of the last byte in each fixed size block
	localparam disk_pos_t DISK_INFO_LAST   = 16'h0037;
	localparam disk_pos_t FILE_COUNT_LAST  = 16'h0001;
	localparam disk_pos_t FILE_HEADER_LAST = 16'h000F;

	// File size field inside a file header block
	localparam disk_pos_t FILE_SIZE_LO_POS = 16'h000D;
	localparam disk_pos_t FILE_SIZE_HI_POS = 16'h000E;

	localparam disk_pos_t DISK_END_POS = 16'd65499;

	// Image is a 16 byte header followed by sides of 65500 bytes
	localparam int SIDE_BYTES   = 65500;
	localparam int HEADER_BYTES = 16;

	// PRG 3C0000 and up holds the disk image
	localparam logic [3:0] DISK_REGION = 4'hF;

endpackage

// ==== src/fds_timer_irq.sv ====
// CPU timer IRQ with reload latch, one-shot and repeat modes, and the I/O enable bit
`timescale 1ns/1ns

module fds_timer_irq (
	input  logic                   clk,
	input  logic                   diskreset,
	input  logic                   ce,
	input  fds_regs_pkg::cpu_bus_t cpu,
	input  logic                   status_read,
	output logic                   timer_irq,
	output logic                   io_en
);

	logic [15:0] timer_latch;
	logic [15:0] timer_cnt;
	logic        timer_en;
	logic        timer_repeat;
	logic        status_read_d;
	logic        timer_start;
	logic        timer_expire;

	assign timer_start  = cpu.data[1] & io_en;
	assign timer_expire = timer_en & (timer_cnt == 16'd0);

	always_ff @(posedge clk) begin
		if (ce) begin
			if (timer_en) begin
				timer_cnt <= timer_expire ? timer_latch : timer_cnt - 16'd1; // Reload on expiry
			end
			if (cpu.write) begin
				case (cpu.addr)
					fds_regs_pkg::REG_TIMER_LO: timer_latch[7:0] <= cpu.data;
					fds_regs_pkg::REG_TIMER_HI: timer_latch[15:8] <= cpu.data;
					fds_regs_pkg::REG_TIMER_CTRL: begin
						if (timer_start) begin
							timer_cnt <= timer_latch;
						end
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (diskreset) begin
			timer_irq     <= 1'b0;
			timer_en      <= 1'b0;
			timer_repeat  <= 1'b0;
			io_en         <= 1'b0;
			status_read_d <= 1'b0;
		end else if (ce) begin
			status_read_d <= status_read;

			if (timer_expire) begin
				timer_irq <= 1'b1;
				if (!timer_repeat) begin
					timer_en <= 1'b0; // One-shot stops here
				end
			end

			if (cpu.write) begin
				case (cpu.addr)
					fds_regs_pkg::REG_TIMER_CTRL: begin
						timer_repeat <= cpu.data[0];
						timer_en     <= timer_start;
						if (!timer_start) begin
							timer_irq <= 1'b0;
						end
					end
					fds_regs_pkg::REG_IO_EN: begin
						io_en <= cpu.data[0];
						if (!cpu.data[0]) begin
							timer_en  <= 1'b0;
							timer_irq <= 1'b0;
						end
					end
					default: ;
				endcase
			end

			// Acknowledge lands one ce after the $4030 read
			if (status_read_d) begin
				timer_irq <= 1'b0;
			end
		end
	end

endmodule

// ==== src/fds_disk_transfer.sv ====
// Disk control register, pre-gap and byte timing, byte flag, block tracking and disk position
`timescale 1ns/1ns

module fds_disk_transfer #(
	parameter int PRE_GAP_DELAY = 65535,
	parameter int BYTE_DELAY    = 99
) (
	input  logic                     clk,
	input  logic                     diskreset,
	input  logic                     ce,
	input  fds_regs_pkg::cpu_bus_t   cpu,
	input  fds_regs_pkg::byte_t      disk_data,
	input  logic                     fds_busy,
	input  logic                     disk_read,
	input  logic                     status_read,
	input  logic                     io_en,
	output fds_regs_pkg::disk_ctrl_t ctrl,
	output fds_disk_pkg::disk_pos_t  disk_pos,
	output logic                     byte_flag,
	output logic                     disk_irq,
	output logic                     disk_end
);

	logic [15:0]               transfer_cnt;
	logic                      after_pre_gap;
	logic                      new_byte;       // Byte arrived and not yet consumed
	logic                      disk_read_d;
	logic                      status_read_d;
	logic                      block_end;
	logic                      last_byte;
	logic                      ctrl_write;
	logic                      xfer_start;
	fds_disk_pkg::disk_pos_t   byte_cnt;       // Bytes read in the current block
	fds_disk_pkg::disk_pos_t   file_size;
	fds_disk_pkg::block_type_t block_type;

	assign ctrl_write = cpu.write & io_en & (cpu.addr == fds_regs_pkg::REG_DISK_CTRL);
	assign xfer_start = ctrl_write & cpu.data[6] & ~ctrl.byte_transfer; // Rising edge of bit 6
	assign disk_end   = (disk_pos == fds_disk_pkg::DISK_END_POS);
	assign disk_irq   = byte_flag & ctrl.disk_irq_en;

	// Image has no CRC bytes, so each block must stop at its own length
	always_comb begin
		case (block_type)
			fds_disk_pkg::BLK_DISK_INFO:   last_byte = (byte_cnt == fds_disk_pkg::DISK_INFO_LAST);
			fds_disk_pkg::BLK_FILE_COUNT:  last_byte = (byte_cnt == fds_disk_pkg::FILE_COUNT_LAST);
			fds_disk_pkg::BLK_FILE_HEADER: last_byte = (byte_cnt == fds_disk_pkg::FILE_HEADER_LAST);
			fds_disk_pkg::BLK_FILE_DATA:   last_byte = (byte_cnt == file_size);
			default:                       last_byte = 1'b0;
		endcase
	end

	// File size comes from the header that precedes the data block
	always_ff @(posedge clk) begin
		if (ce && disk_read && block_type == fds_disk_pkg::BLK_FILE_HEADER) begin
			if (byte_cnt == fds_disk_pkg::FILE_SIZE_LO_POS) begin
				file_size[7:0] <= disk_data;
			end
			if (byte_cnt == fds_disk_pkg::FILE_SIZE_HI_POS) begin
				file_size[15:8] <= disk_data;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (diskreset) begin
			ctrl          <= '0;
			transfer_cnt  <= 16'd0;
			after_pre_gap <= 1'b0;
			new_byte      <= 1'b0;
			disk_read_d   <= 1'b0;
			status_read_d <= 1'b0;
			byte_flag     <= 1'b0;
			byte_cnt      <= '0;
			block_end     <= 1'b0;
			block_type    <= fds_disk_pkg::BLK_NONE;
			disk_pos      <= '0;
		end else if (ce) begin
			disk_read_d   <= disk_read;
			status_read_d <= status_read;

			if (ctrl_write) begin
				ctrl.motor_on      <= cpu.data[0];
				ctrl.head_rewind   <= cpu.data[1];
				ctrl.vertical      <= ~cpu.data[3];
				ctrl.byte_transfer <= cpu.data[6];
				ctrl.disk_irq_en   <= cpu.data[7];
			end

			if (disk_read && byte_cnt == '0) begin
				block_type <= fds_disk_pkg::block_type_t'(disk_data[2:0]);
			end

			if (status_read_d || disk_read_d) begin
				byte_flag <= 1'b0;
			end

			// Advance one ce after the $4031 read
			if (disk_read_d && new_byte) begin
				new_byte <= 1'b0;
				byte_cnt <= byte_cnt + 16'd1;
				if (!disk_end && !block_end) begin
					disk_pos <= disk_pos + 16'd1;
				end
				if (last_byte) begin
					block_end <= 1'b1;
				end
			end

			if (xfer_start) begin // New block
				byte_flag  <= 1'b0;
				new_byte   <= 1'b0;
				byte_cnt   <= '0;
				block_end  <= 1'b0;
				block_type <= fds_disk_pkg::BLK_NONE;
			end

			if (!ctrl.motor_on) begin
				transfer_cnt <= 16'd0;
			end else if (ctrl.head_rewind) begin
				transfer_cnt  <= 16'd0;
				disk_pos      <= '0;
				after_pre_gap <= 1'b0;
			end else if (!after_pre_gap) begin
				if (transfer_cnt == 16'(PRE_GAP_DELAY)) begin
					after_pre_gap <= 1'b1;
					transfer_cnt  <= 16'd0;
				end else begin
					transfer_cnt <= transfer_cnt + 16'd1;
				end
			end else if (xfer_start) begin
				transfer_cnt <= 16'd0; // Realign byte timing to the block
			end else if (transfer_cnt == 16'(BYTE_DELAY)) begin
				transfer_cnt <= 16'd0;
				if (ctrl.byte_transfer && !fds_busy) begin
					byte_flag <= 1'b1;
					new_byte  <= 1'b1;
				end
			end else begin
				transfer_cnt <= transfer_cnt + 16'd1;
			end
		end
	end

endmodule

// ==== src/fds_side_select.sv ====
// Eject button edge detect, disk side counter and minimum eject hold timer
`timescale 1ns/1ns

module fds_side_select #(
	parameter int EJECT_DELAY = 1786800
) (
	input  logic                     clk,
	input  logic                     diskreset,
	input  logic                     ce,
	input  logic                     eject_btn,
	input  fds_disk_pkg::disk_side_t max_diskside,
	output fds_disk_pkg::disk_side_t side,
	output logic                     disk_eject
);

	localparam int CNT_W = $clog2(EJECT_DELAY + 1);

	logic             eject_btn_d;
	logic             eject_hold;
	logic [CNT_W-1:0] eject_cnt;
	logic             btn_rise;

	assign btn_rise = eject_btn & ~eject_btn_d;

	// Held button keeps the disk out beyond the minimum time
	assign disk_eject = eject_hold | eject_btn;

	always_ff @(posedge clk) begin
		if (diskreset) begin
			eject_btn_d <= 1'b0;
			eject_hold  <= 1'b0;
			eject_cnt   <= '0;
			side        <= '0;
		end else if (ce) begin
			eject_btn_d <= eject_btn;
			if (btn_rise) begin
				side       <= (side >= max_diskside) ? 2'd0 : side + 2'd1;
				eject_hold <= 1'b1;
				eject_cnt  <= '0;
			end else if (eject_hold) begin
				if (eject_cnt == CNT_W'(EJECT_DELAY - 1)) begin
					eject_hold <= 1'b0; // Disk back in
				end else begin
					eject_cnt <= eject_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// ==== src/fds_prg_map.sv ====
// Status register readout, PRG address arbitration between CPU and disk, CHR and VRAM mapping
`timescale 1ns/1ns

module fds_prg_map (
	input  fds_regs_pkg::cpu_bus_t   cpu,
	input  fds_regs_pkg::disk_ctrl_t ctrl,
	input  fds_disk_pkg::disk_pos_t  disk_pos,
	input  fds_disk_pkg::disk_side_t side,
	input  logic                     timer_irq,
	input  logic                     byte_flag,
	input  logic                     disk_end,
	input  logic                     disk_eject,
	input  logic [13:0]              chr_ain,
	output fds_regs_pkg::prg_addr_t  prg_aout,
	output fds_regs_pkg::byte_t      prg_dout,
	output logic                     prg_allow,
	output logic                     prg_bus_write,
	output logic                     status_read,
	output logic                     disk_read,
	output fds_regs_pkg::chr_addr_t  chr_aout,
	output logic                     vram_a10,
	output logic                     vram_ce
);

	localparam fds_regs_pkg::prg_addr_t WRAM_BASE = 22'h008000;

	logic        disk_ready;
	logic        prg_is_ram;
	logic [14:0] ram_offset;
	logic [17:0] side_offset;
	logic [17:0] image_offset;

	assign status_read = cpu.read & (cpu.addr == fds_regs_pkg::REG_IRQ_STATUS);
	assign disk_read   = cpu.read & (cpu.addr == fds_regs_pkg::REG_DISK_DATA);
	assign disk_ready  = ctrl.motor_on & ~ctrl.head_rewind & ~disk_eject & ~disk_end;

	always_comb begin
		prg_bus_write = 1'b1; // Drive owns the data bus
		case (cpu.addr)
			fds_regs_pkg::REG_IRQ_STATUS: begin
				prg_dout = {1'b0, disk_end, 4'd0, byte_flag, timer_irq};
			end
			fds_regs_pkg::REG_DRIVE_STATUS: begin
				prg_dout = {4'h4, 1'b0, disk_eject, ~disk_ready, disk_eject};
			end
			fds_regs_pkg::REG_EXT_STATUS: begin
				prg_dout = fds_regs_pkg::EXT_STATUS_VAL;
			end
			default: begin
				prg_dout      = 8'h00;
				prg_bus_write = 1'b0;
			end
		endcase
	end

	assign prg_is_ram = cpu.addr[15] ^ (&cpu.addr[14:13]); // $6000-$DFFF
	assign ram_offset = 15'(cpu.addr - 16'h6000);

	// Header, then one fixed size region per side
	assign side_offset  = 18'(fds_disk_pkg::HEADER_BYTES) +
		18'(side) * 18'(fds_disk_pkg::SIDE_BYTES);
	assign image_offset = side_offset + 18'(disk_pos);

	// Disk data read has priority over the CPU mapping
	always_comb begin
		if (disk_read) begin
			prg_aout = {fds_disk_pkg::DISK_REGION, image_offset};
		end else if (prg_is_ram) begin
			prg_aout = WRAM_BASE + 22'(ram_offset);
		end else begin
			prg_aout = 22'(cpu.addr[12:0]); // BIOS
		end
	end

	assign prg_allow = (cpu.read & cpu.addr[15] & ~prg_bus_write) | prg_is_ram | disk_read;

	// CHR is all RAM
	assign chr_aout = {9'b1_0000_0000, chr_ain[12:0]};
	assign vram_a10 = ctrl.vertical ? chr_aout[10] : chr_aout[11];
	assign vram_ce  = chr_ain[13];

endmodule

// ==== src/fds_drive.sv ====
// Disk drive top level with timer, transfer, side select and PRG map instances
`timescale 1ns/1ns

module fds_drive #(
	parameter int PRE_GAP_DELAY = 65535,
	parameter int BYTE_DELAY    = 99,
	parameter int EJECT_DELAY   = 1786800
) (
	input  logic                     clk,
	input  logic                     diskreset,
	input  logic                     ce,
	input  fds_regs_pkg::cpu_addr_t  prg_ain,
	input  fds_regs_pkg::byte_t      prg_din,
	input  logic                     prg_read,
	input  logic                     prg_write,
	input  fds_regs_pkg::byte_t      prg_dbus,
	input  logic [13:0]              chr_ain,
	input  logic                     fds_busy,
	input  logic                     eject_btn,
	input  fds_disk_pkg::disk_side_t max_diskside,
	output fds_regs_pkg::prg_addr_t  prg_aout,
	output fds_regs_pkg::byte_t      prg_dout,
	output logic                     prg_allow,
	output logic                     prg_bus_write,
	output fds_regs_pkg::chr_addr_t  chr_aout,
	output logic                     vram_a10,
	output logic                     vram_ce,
	output logic                     irq,
	output fds_disk_pkg::disk_side_t diskside
);

	fds_regs_pkg::cpu_bus_t   cpu;
	fds_regs_pkg::disk_ctrl_t ctrl;
	fds_disk_pkg::disk_pos_t  disk_pos;
	fds_disk_pkg::disk_side_t side;
	logic                     timer_irq;
	logic                     io_en;
	logic                     byte_flag;
	logic                     disk_irq;
	logic                     disk_end;
	logic                     disk_eject;
	logic                     status_read;
	logic                     disk_read;

	assign cpu      = '{addr: prg_ain, data: prg_din, read: prg_read, write: prg_write};
	assign irq      = timer_irq | disk_irq;
	assign diskside = side;

	fds_timer_irq u_timer (
		.clk(clk), .diskreset(diskreset), .ce(ce), .cpu(cpu),
		.status_read(status_read), .timer_irq(timer_irq), .io_en(io_en)
	);

	fds_disk_transfer #(.PRE_GAP_DELAY(PRE_GAP_DELAY), .BYTE_DELAY(BYTE_DELAY)) u_transfer (
		.clk(clk), .diskreset(diskreset), .ce(ce), .cpu(cpu), .disk_data(prg_dbus),
		.fds_busy(fds_busy), .disk_read(disk_read), .status_read(status_read), .io_en(io_en),
		.ctrl(ctrl), .disk_pos(disk_pos), .byte_flag(byte_flag), .disk_irq(disk_irq),
		.disk_end(disk_end)
	);

	fds_side_select #(.EJECT_DELAY(EJECT_DELAY)) u_side (
		.clk(clk), .diskreset(diskreset), .ce(ce), .eject_btn(eject_btn),
		.max_diskside(max_diskside), .side(side), .disk_eject(disk_eject)
	);

	fds_prg_map u_map (
		.cpu(cpu), .ctrl(ctrl), .disk_pos(disk_pos), .side(side), .timer_irq(timer_irq),
		.byte_flag(byte_flag), .disk_end(disk_end), .disk_eject(disk_eject), .chr_ain(chr_ain),
		.prg_aout(prg_aout), .prg_dout(prg_dout), .prg_allow(prg_allow),
		.prg_bus_write(prg_bus_write), .status_read(status_read), .disk_read(disk_read),
		.chr_aout(chr_aout), .vram_a10(vram_a10), .vram_ce(vram_ce)
	);

endmodule

// ==== testbench/fds_drive_asserts.sv ====
// Concurrent assertions on reset, disk data reads and side range, bound to fds_drive
`timescale 1ns/1ns

module fds_drive_asserts (
	input logic                     clk,
	input logic                     diskreset,
	input fds_regs_pkg::cpu_addr_t  prg_ain,
	input logic                     prg_read,
	input fds_regs_pkg::prg_addr_t  prg_aout,
	input logic                     prg_allow,
	input logic                     prg_bus_write,
	input logic                     irq,
	input fds_disk_pkg::disk_side_t diskside,
	input fds_disk_pkg::disk_side_t max_diskside
);

	int assert_fails = 0;

	irq_low_in_reset: assert property (@(posedge clk) diskreset |=> !irq)
		else begin
			$error("irq is high while the drive is held in reset");
			assert_fails++;
		end

	// Disk image bytes come from the image region and reach the CPU
	disk_read_allowed: assert property (@(posedge clk)
		(prg_read && prg_ain == fds_regs_pkg::REG_DISK_DATA) |->
		(prg_allow && !prg_bus_write && prg_aout[21:18] == fds_disk_pkg::DISK_REGION))
		else begin
			$error("disk data read is not routed to the disk image");
			assert_fails++;
		end

	side_in_range: assert property (@(posedge clk) disable iff (diskreset)
		diskside <= max_diskside)
		else begin
			$error("diskside is above max_diskside");
			assert_fails++;
		end

endmodule

bind fds_drive fds_drive_asserts u_asserts (
	.clk(clk), .diskreset(diskreset), .prg_ain(prg_ain), .prg_read(prg_read),
	.prg_aout(prg_aout), .prg_allow(prg_allow), .prg_bus_write(prg_bus_write),
	.irq(irq), .diskside(diskside), .max_diskside(max_diskside)
);

// ==== testbench/fds_drive_tests.svh ====
// Directed tests for timer IRQ, disk reads, block end, side switching and address mapping

	// Header first, then one fixed size region per side
	function automatic fds_regs_pkg::prg_addr_t expected_disk_addr(input int side_num,
		input int pos);
		int offset;
		offset = fds_disk_pkg::HEADER_BYTES + side_num * fds_disk_pkg::SIDE_BYTES + pos;
		return {fds_disk_pkg::DISK_REGION, offset[17:0]};
	endfunction

	task automatic start_disk();
		cpu_write(fds_regs_pkg::REG_IO_EN, 8'h01);
		cpu_write(fds_regs_pkg::REG_DISK_CTRL, 8'hC1); // Motor, transfer, disk IRQ
	endtask

	task automatic read_disk_byte(input fds_regs_pkg::byte_t data, input int side_num,
		input int pos);
		wait_irq(1'b1);
		cpu_read(fds_regs_pkg::REG_DISK_DATA, data);
		check_prg_addr("prg_aout", seen_aout, expected_disk_addr(side_num, pos));
		check_bit("prg_allow", seen_allow, 1'b1);
	endtask

	task automatic timer_irq_test();
		int errors_before;
		int latch;
		int t_start;
		int t_rise;
		errors_before = error_count;
		latch = 6 + ($random(seed) & 7);
		reset_dut();
		cpu_write(fds_regs_pkg::REG_IO_EN, 8'h01);
		cpu_write(fds_regs_pkg::REG_TIMER_LO, 8'(latch));
		cpu_write(fds_regs_pkg::REG_TIMER_HI, 8'h00);
		cpu_write(fds_regs_pkg::REG_TIMER_CTRL, 8'h02); // One-shot
		@(negedge clk);
		t_start = ce_count;
		wait_irq(1'b1);
		check_count("one-shot delay", ce_count - t_start, latch + 1);
		cpu_read(fds_regs_pkg::REG_IRQ_STATUS, 8'h00);
		check_bit("irq_status[0]", seen_dout[0], 1'b1);
		@(negedge clk);
		check_bit("irq", irq, 1'b1);
		next_ce();
		@(negedge clk);
		check_bit("irq", irq, 1'b0); // Acknowledged one ce after the read
		repeat (latch + 3) next_ce();
		@(negedge clk);
		check_bit("irq", irq, 1'b0);

		cpu_write(fds_regs_pkg::REG_TIMER_CTRL, 8'h03); // Repeat
		@(negedge clk);
		t_start = ce_count;
		wait_irq(1'b1);
		t_rise = ce_count;
		check_count("repeat first delay", t_rise - t_start, latch + 1);
		cpu_read(fds_regs_pkg::REG_IRQ_STATUS, 8'h00);
		wait_irq(1'b0);
		wait_irq(1'b1);
		check_count("repeat period", ce_count - t_rise, latch + 1);
		report_test("timer_irq", errors_before);
	endtask

	task automatic disk_read_test();
		int errors_before;
		int pos;
		errors_before = error_count;
		reset_dut();
		start_disk();
		for (pos = 0; pos < 4; pos++) begin
			read_disk_byte((pos == 0) ? 8'h01 : 8'hA5 ^ 8'(pos), 0, pos); // Disk info block
		end
		report_test("disk_read", errors_before);
	endtask

	task automatic block_end_test();
		int errors_before;
		errors_before = error_count;
		reset_dut();
		start_disk();
		read_disk_byte(8'h02, 0, 0); // File count block, two bytes long
		read_disk_byte(8'h01, 0, 1);
		read_disk_byte(8'h00, 0, 2);
		read_disk_byte(8'h00, 0, 2);
		cpu_write(fds_regs_pkg::REG_DISK_CTRL, 8'h81);
		cpu_write(fds_regs_pkg::REG_DISK_CTRL, 8'hC1); // New block
		read_disk_byte(8'h03, 0, 2);
		read_disk_byte(8'h00, 0, 3);
		report_test("block_end", errors_before);
	endtask

	task automatic side_switch_test();
		int errors_before;
		int n;
		errors_before = error_count;
		reset_dut();
		next_ce();
		prg_ain   <= fds_regs_pkg::REG_DRIVE_STATUS;
		prg_read  <= 1'b1;
		eject_btn <= 1'b1;
		next_ce(); // Button edge taken here
		eject_btn <= 1'b0;
		@(negedge clk);
		check_side("diskside", diskside, 2'd1);
		n = 0;
		while (prg_dout[0] === 1'b1 && n < WAIT_LIMIT) begin
			check_bit("drive_status[2]", prg_dout[2], 1'b1);
			next_ce();
			@(negedge clk);
			n++;
		end
		check_count("eject ce strobes", n, EJECT_DELAY);
		start_disk();
		read_disk_byte(8'h01, 1, 0);

		next_ce();
		eject_btn <= 1'b1;
		next_ce();
		eject_btn <= 1'b0;
		@(negedge clk);
		check_side("diskside", diskside, 2'd0); // Wrapped past max_diskside
		report_test("side_switch", errors_before);
	endtask

	task automatic mapping_test();
		int errors_before;
		errors_before = error_count;
		reset_dut();
		cpu_read(16'h6000, 8'h00);
		check_prg_addr("prg_aout", seen_aout, 22'h008000);
		check_bit("prg_allow", seen_allow, 1'b1);
		cpu_read(16'hE000, 8'h00);
		check_prg_addr("prg_aout", seen_aout, 22'h000000);
		cpu_read(fds_regs_pkg::REG_EXT_STATUS, 8'h00);
		check_byte("prg_dout", seen_dout, 8'h80);
		check_bit("prg_bus_write", seen_bus_write, 1'b1);

		next_ce();
		chr_ain <= 14'h0400; // A10 set, A11 clear
		cpu_write(fds_regs_pkg::REG_IO_EN, 8'h01);
		cpu_write(fds_regs_pkg::REG_DISK_CTRL, 8'h00);
		@(negedge clk);
		check_bit("vram_a10", vram_a10, 1'b1);
		check_chr_addr("chr_aout", chr_aout, 22'h200400); // CHR RAM starts at 200000
		check_bit("vram_ce", vram_ce, 1'b0);
		cpu_write(fds_regs_pkg::REG_DISK_CTRL, 8'h08); // Horizontal
		@(negedge clk);
		check_bit("vram_a10", vram_a10, 1'b0);
		next_ce();
		chr_ain <= 14'h2800; // Nametable access with A11 set
		@(negedge clk);
		check_bit("vram_a10", vram_a10, 1'b1);
		check_chr_addr("chr_aout", chr_aout, 22'h200800);
		check_bit("vram_ce", vram_ce, 1'b1);
		report_test("mapping", errors_before);
	endtask

// ==== testbench/tb_fds_drive.sv ====
// Testbench top with clock, reset, DUT, bus helpers, compare tasks and result summary
`timescale 1ns/1ns

module tb_fds_drive;

	localparam int PRE_GAP_DELAY = 20;
	localparam int BYTE_DELAY    = 9;
	localparam int EJECT_DELAY   = 30;
	localparam int WAIT_LIMIT    = 200; // ce strobes before a wait gives up

	logic                     clk;
	logic                     diskreset;
	logic                     ce;
	fds_regs_pkg::cpu_addr_t  prg_ain;
	fds_regs_pkg::byte_t      prg_din;
	logic                     prg_read;
	logic                     prg_write;
	fds_regs_pkg::byte_t      prg_dbus;
	logic [13:0]              chr_ain;
	logic                     fds_busy;
	logic                     eject_btn;
	fds_disk_pkg::disk_side_t max_diskside;
	fds_regs_pkg::prg_addr_t  prg_aout;
	fds_regs_pkg::byte_t      prg_dout;
	logic                     prg_allow;
	logic                     prg_bus_write;
	fds_regs_pkg::chr_addr_t  chr_aout;
	logic                     vram_a10;
	logic                     vram_ce;
	logic                     irq;
	fds_disk_pkg::disk_side_t diskside;

	// Outputs captured while the last CPU access was on the bus
	fds_regs_pkg::byte_t     seen_dout;
	fds_regs_pkg::prg_addr_t seen_aout;
	logic                    seen_allow;
	logic                    seen_bus_write;

	int     ce_count;
	int     check_total;
	int     error_count;
	int     test_total;
	integer seed;

	fds_drive #(
		.PRE_GAP_DELAY(PRE_GAP_DELAY),
		.BYTE_DELAY(BYTE_DELAY),
		.EJECT_DELAY(EJECT_DELAY)
	) u_dut (
		.clk(clk), .diskreset(diskreset), .ce(ce), .prg_ain(prg_ain), .prg_din(prg_din),
		.prg_read(prg_read), .prg_write(prg_write), .prg_dbus(prg_dbus), .chr_ain(chr_ain),
		.fds_busy(fds_busy), .eject_btn(eject_btn), .max_diskside(max_diskside),
		.prg_aout(prg_aout), .prg_dout(prg_dout), .prg_allow(prg_allow),
		.prg_bus_write(prg_bus_write), .chr_aout(chr_aout), .vram_a10(vram_a10),
		.vram_ce(vram_ce), .irq(irq), .diskside(diskside)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		ce <= ~ce; // Strobe on every other clock
		if (ce) begin
			ce_count <= ce_count + 1;
		end
	end

	task automatic check_byte(input string name, input fds_regs_pkg::byte_t actual,
		input fds_regs_pkg::byte_t expected);
		check_total++;
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_prg_addr(input string name, input fds_regs_pkg::prg_addr_t actual,
		input fds_regs_pkg::prg_addr_t expected);
		check_total++;
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_chr_addr(input string name, input fds_regs_pkg::chr_addr_t actual,
		input fds_regs_pkg::chr_addr_t expected);
		check_total++;
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		check_total++;
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
		end
	endtask

	task automatic check_side(input string name, input fds_disk_pkg::disk_side_t actual,
		input fds_disk_pkg::disk_side_t expected);
		check_total++;
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	task automatic check_count(input string name, input int actual, input int expected);
		check_total++;
		if (actual != expected) begin
			error_count++;
			$display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	// Returns on the next clock edge that carries a ce strobe
	task automatic next_ce();
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (ce !== 1'b1 && n < 4);
		if (ce !== 1'b1) begin
			error_count++;
			$display("No ce strobe arrived within 4 clocks at %0t ns", $time);
		end
	endtask

	task automatic reset_dut();
		@(posedge clk);
		diskreset <= 1'b1;
		prg_read  <= 1'b0;
		prg_write <= 1'b0;
		eject_btn <= 1'b0;
		repeat (5) @(posedge clk);
		diskreset <= 1'b0;
	endtask

	// Access is presented after one ce edge and taken on the next
	task automatic bus_cycle(input fds_regs_pkg::cpu_addr_t addr, input fds_regs_pkg::byte_t data,
		input logic rd, input logic wr, input fds_regs_pkg::byte_t dbus);
		next_ce();
		prg_ain   <= addr;
		prg_din   <= data;
		prg_read  <= rd;
		prg_write <= wr;
		prg_dbus  <= dbus;
		@(negedge clk);
		seen_dout      = prg_dout;
		seen_aout      = prg_aout;
		seen_allow     = prg_allow;
		seen_bus_write = prg_bus_write;
		next_ce();
		prg_read  <= 1'b0;
		prg_write <= 1'b0;
	endtask

	task automatic cpu_write(input fds_regs_pkg::cpu_addr_t addr, input fds_regs_pkg::byte_t data);
		bus_cycle(addr, data, 1'b0, 1'b1, 8'h00);
	endtask

	// dbus is the image byte the cartridge returns for this read
	task automatic cpu_read(input fds_regs_pkg::cpu_addr_t addr, input fds_regs_pkg::byte_t dbus);
		bus_cycle(addr, 8'h00, 1'b1, 1'b0, dbus);
	endtask

	task automatic wait_irq(input logic level);
		int n;
		n = 0;
		do begin
			next_ce();
			@(negedge clk);
			n++;
		end while (irq !== level && n < WAIT_LIMIT);
		if (irq !== level) begin
			error_count++;
			$display("Timed out at %0t ns waiting for irq to go %b", $time, level);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_total++;
		if (error_count == errors_before) begin
			$display("%s: passed", name);
		end else begin
			$display("%s: failed with %0d errors", name, error_count - errors_before);
		end
	endtask

	`include "fds_drive_tests.svh"

	initial begin
		seed         = 32'hd853b803;
		ce_count     = 0;
		check_total  = 0;
		error_count  = 0;
		test_total   = 0;
		diskreset    = 1'b1;
		ce           = 1'b0;
		prg_ain      = 16'h0000;
		prg_din      = 8'h00;
		prg_read     = 1'b0;
		prg_write    = 1'b0;
		prg_dbus     = 8'h00;
		chr_ain      = 14'h0000;
		fds_busy     = 1'b0;
		eject_btn    = 1'b0;
		max_diskside = 2'd1; // Two sided disk

		timer_irq_test();
		disk_read_test();
		block_end_test();
		side_switch_test();
		mapping_test();

		$display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
			test_total, check_total, error_count, u_dut.u_asserts.assert_fails);
		if (error_count == 0 && u_dut.u_asserts.assert_fails == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== fds_drive.f ====
+incdir+testbench
src/fds_regs_pkg.sv
src/fds_disk_pkg.sv
src/fds_timer_irq.sv
src/fds_disk_transfer.sv
src/fds_side_select.sv
src/fds_prg_map.sv
src/fds_drive.sv
testbench/fds_drive_asserts.sv
testbench/tb_fds_drive.sv
